// ==== exec_cluster.f ====
isa_pkg.sv
ooo_pkg.sv
reservation_station.sv
fu_scheduler.sv
alu_unit.sv
mul_unit.sv
div_unit.sv
result_arbiter.sv
exec_cluster.sv
tb_exec_cluster.sv

// ==== tb_exec_cluster.sv ====
// Testbench for the execute cluster.
// Applies a table of micro-ops and checks every result-bus beat against
// a behavioral model, with one completion expected per dispatched tag.

`timescale 1ns/1ns
`default_nettype none

module tb_exec_cluster;

    import isa_pkg::*;
    import ooo_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;
    localparam int MAX_ROWS   = 64;

    typedef struct packed {
        alu_op_t  op;
        xlen_t    a;            // Producer's value when dep is set.
        xlen_t    b;
        logic     dep;          // Source 1 waits on src_tag.
        rob_tag_t src_tag;
        rob_tag_t dest;
        xlen_t    exp;
    } row_t;

    logic        clk;
    logic        rst;
    logic        dispatch_valid;
    rs_entry_t   dispatch_entry;
    logic        rs_full;
    result_t     result_bus;

    row_t        rows [MAX_ROWS];
    int          num_rows;
    xlen_t       tag_value [16];    // Model value per tag while the table is built.
    xlen_t       exp_of_tag [16];
    int          row_of_tag [16];
    logic [15:0] pending;           // Tags dispatched and not yet seen on the bus.
    int          done_order [MAX_ROWS];
    int          completed;
    logic        saw_full;
    logic        table_ready;
    integer      seed;
    int          dep_row;
    int          indep_row;

    exec_cluster #(
        .MUL_STAGES (2)
    ) DUT (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_entry (dispatch_entry),
        .rs_full        (rs_full),
        .result_bus     (result_bus)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // Reference model and table helpers.
    function automatic xlen_t model(alu_op_t op, xlen_t a, xlen_t b);
        logic [63:0] prod;
        xlen_t       r;
        prod = {32'h0, a} * {32'h0, b};
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << b[4:0];
            OP_SRL:  r = a >> b[4:0];
            OP_SRA:  r = $signed(a) >>> b[4:0];
            OP_MUL:  r = prod[31:0];
            OP_MULH: r = prod[63:32];
            OP_DIVU: r = (b == 0) ? 32'hffff_ffff : a / b;
            OP_REMU: r = (b == 0) ? a : a % b;
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic add_row(alu_op_t op, xlen_t a, xlen_t b, logic dep,
                           rob_tag_t src_tag, rob_tag_t dest);
        row_t r;
        r.op      = op;
        r.a       = dep ? tag_value[src_tag] : a;
        r.b       = b;
        r.dep     = dep;
        r.src_tag = src_tag;
        r.dest    = dest;
        r.exp     = model(op, r.a, b);
        tag_value[dest] = r.exp;
        rows[num_rows]  = r;
        num_rows++;
    endtask

    task automatic check(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    // ====================
    // Dispatch side. A tag is not reused while it is still in flight.
    task automatic apply_row(int idx);
        row_t      r;
        rs_entry_t e;
        r = rows[idx];
        while (rs_full || pending[r.dest]) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        e             = '0;
        e.valid       = 1'b1;
        e.op          = r.op;
        e.dest        = r.dest;
        e.src1.ready  = !(r.dep && pending[r.src_tag]);
        e.src1.tag    = r.src_tag;
        e.src1.value  = e.src1.ready ? r.a : '0;
        e.src2.ready  = 1'b1;
        e.src2.value  = r.b;
        pending[r.dest]    = 1'b1;
        exp_of_tag[r.dest] = r.exp;
        row_of_tag[r.dest] = idx;
        dispatch_entry = e;
        dispatch_valid = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        dispatch_valid = 1'b0;
    endtask

    task automatic note_result(rob_tag_t tag, xlen_t value);
        check($sformatf("tag %0d in flight", tag), pending[tag], 1'b1);
        check($sformatf("tag %0d value", tag), value, exp_of_tag[tag]);
        pending[tag] = 1'b0;
        done_order[row_of_tag[tag]] = completed;
        completed++;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (rs_full) begin
                saw_full = 1'b1;
            end
            if (result_bus.valid) begin
                note_result(result_bus.tag, result_bus.value);
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = (num_rows * 40 + 200) * CLK_PERIOD;     // Forty cycles per row plus margin.
        #(limit);
        $display("Timeout: the run did not finish within %0d cycles", limit / CLK_PERIOD);
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

    // ====================
    initial begin : main
        int      k;
        alu_op_t op;
        clk            = 1'b0;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_entry = '0;
        pending        = '0;
        completed      = 0;
        saw_full       = 1'b0;
        num_rows       = 0;
        table_ready    = 1'b0;
        seed           = 32'h59c0_2ed4;
        for (int t = 0; t < 16; t++) begin
            tag_value[t] = '0;
        end

        add_row(OP_ADD, 32'h7fff_fff0, 32'h0000_0025, 1'b0, 0, 0);
        add_row(OP_SUB, 32'h0000_0010, 32'h0000_0020, 1'b0, 0, 1);
        add_row(OP_AND, 32'hf0f0_1234, 32'h0ff0_ff00, 1'b0, 0, 2);
        add_row(OP_OR,  32'hf0f0_1234, 32'h0ff0_ff00, 1'b0, 0, 3);
        add_row(OP_XOR, 32'hf0f0_1234, 32'h0ff0_ff00, 1'b0, 0, 4);
        add_row(OP_SLL, 32'h8000_0001, 32'h0000_0024, 1'b0, 0, 5);   // Only 5 bits count.
        add_row(OP_SRL, 32'h8000_0000, 32'h0000_0007, 1'b0, 0, 6);
        add_row(OP_SRA, 32'h8000_0000, 32'h0000_0007, 1'b0, 0, 7);
        add_row(OP_MUL,  32'hffff_ffff, 32'h0000_0003, 1'b0, 0, 8);
        add_row(OP_MULH, 32'hffff_ffff, 32'h0000_0003, 1'b0, 0, 9);
        for (int i = 0; i < 4; i++) begin
            add_row(OP_MUL, 32'h1234_5678 + i * 32'h0101_0101, 32'h9abc_def0 - i,
                    1'b0, 0, rob_tag_t'(10 + i));
        end
        add_row(OP_DIVU, 32'd1000, 32'd7, 1'b0, 0, 14);
        add_row(OP_REMU, 32'd1000, 32'd7, 1'b0, 0, 15);
        add_row(OP_DIVU, 32'h1357_9bdf, 32'd0, 1'b0, 0, 0);
        add_row(OP_REMU, 32'h1357_9bdf, 32'd0, 1'b0, 0, 1);

        // The add waits on the slow divide; the xor behind it should finish first.
        add_row(OP_DIVU, 32'hffff_fff0, 32'd3, 1'b0, 0, 2);
        dep_row = num_rows;
        add_row(OP_ADD, 32'h0, 32'd5, 1'b1, 2, 3);
        indep_row = num_rows;
        add_row(OP_XOR, 32'h00ff_00ff, 32'h0f0f_0f0f, 1'b0, 0, 4);

        for (int i = 0; i < 6; i++) begin
            add_row((i % 2) ? OP_REMU : OP_DIVU, 32'hdead_beef - i * 32'h1111,
                    32'd3 + i * 7, 1'b0, 0, rob_tag_t'(5 + i));
        end

        for (int i = 0; i < 24; i++) begin
            k = $unsigned($random(seed)) % 10;
            if (k == 8) begin
                op = OP_MUL;
            end else if (k == 9) begin
                op = OP_MULH;
            end else begin
                op = alu_op_t'(k);
            end
            add_row(op, $random(seed), $random(seed), 1'b0, 0, rob_tag_t'((11 + i) % 16));
        end
        table_ready = 1'b1;

        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        check("result_bus valid after reset", result_bus.valid, 1'b0);
        check("rs_full after reset", rs_full, 1'b0);

        for (int i = 0; i < num_rows; i++) begin
            apply_row(i);
        end
        while (pending != '0) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        repeat (50) @(posedge clk);     // Quiet tail so a late duplicate beat is caught.
        #DRIVE_DLY;

        check("rs_full seen while the divides queue", saw_full, 1'b1);
        check("rs_full after drain", rs_full, 1'b0);
        check("independent xor completes before the dependent add",
              done_order[indep_row] < done_order[dep_row], 1'b1);
        if (completed == num_rows) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("Only %0d of %0d tags completed", completed, num_rows);
            $display("RESULT: FAIL");
            $fatal(1, "Completion count wrong");
        end
    end

endmodule

`default_nettype wire

// ==== exec_cluster.sv ====
// Execute cluster top level.
// Reservation station, scheduler, two ALUs, multiplier, divider and
// the result-bus arbiter.

`timescale 1ns/1ns
`default_nettype none

module exec_cluster #(
    parameter int MUL_STAGES = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               dispatch_valid,
    input  ooo_pkg::rs_entry_t dispatch_entry,
    output logic               rs_full,
    output ooo_pkg::result_t   result_bus
);

    import ooo_pkg::*;

    rs_entry_t         rs_entries [NUM_RS];
    logic [NUM_RS-1:0] rs_consume;
    issue_t            issue;
    logic [NUM_FU-1:0] fu_start;
    logic [NUM_FU-1:0] fu_ready;
    logic [NUM_FU-1:0] fu_grant;
    result_t           fu_results [NUM_FU];

    // ====================
    // Issue side.
    reservation_station u_rs (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_entry (dispatch_entry),
        .rs_consume     (rs_consume),
        .result_bus     (result_bus),       // Wakeup source.
        .rs_entries     (rs_entries),
        .rs_full        (rs_full)
    );

    fu_scheduler u_sched (
        .rs_entries (rs_entries),
        .fu_ready   (fu_ready),
        .issue      (issue),
        .fu_start   (fu_start),
        .rs_consume (rs_consume)
    );

    // ====================
    // Functional units.
    alu_unit u_alu0 (
        .clk    (clk),
        .rst    (rst),
        .start  (fu_start[FU_ALU0]),
        .issue  (issue),
        .grant  (fu_grant[FU_ALU0]),
        .ready  (fu_ready[FU_ALU0]),
        .result (fu_results[FU_ALU0])
    );

    alu_unit u_alu1 (
        .clk    (clk),
        .rst    (rst),
        .start  (fu_start[FU_ALU1]),
        .issue  (issue),
        .grant  (fu_grant[FU_ALU1]),
        .ready  (fu_ready[FU_ALU1]),
        .result (fu_results[FU_ALU1])
    );

    mul_unit #(
        .MUL_STAGES (MUL_STAGES)
    ) u_mul (
        .clk    (clk),
        .rst    (rst),
        .start  (fu_start[FU_MUL]),
        .issue  (issue),
        .grant  (fu_grant[FU_MUL]),
        .ready  (fu_ready[FU_MUL]),
        .result (fu_results[FU_MUL])
    );

    div_unit u_div (
        .clk    (clk),
        .rst    (rst),
        .start  (fu_start[FU_DIV]),
        .issue  (issue),
        .grant  (fu_grant[FU_DIV]),
        .ready  (fu_ready[FU_DIV]),
        .result (fu_results[FU_DIV])
    );

    result_arbiter u_arb (
        .clk        (clk),
        .rst        (rst),
        .fu_results (fu_results),
        .fu_grant   (fu_grant),
        .result_bus (result_bus)
    );

endmodule

`default_nettype wire

// ==== result_arbiter.sv ====
// Result-bus arbiter.
// Grants one requesting unit per cycle in round-robin order and
// registers its result onto the shared bus.

`timescale 1ns/1ns
`default_nettype none

module result_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  ooo_pkg::result_t           fu_results [ooo_pkg::NUM_FU],
    output logic [ooo_pkg::NUM_FU-1:0] fu_grant,
    output ooo_pkg::result_t           result_bus
);

    import ooo_pkg::*;

    fu_idx_t last_win;
    fu_idx_t win;
    fu_idx_t idx;
    logic    any_req;

    // Scan from the farthest offset down; the nearest requester after
    // last_win is the one left in win.
    always_comb begin
        win     = last_win;
        any_req = 1'b0;
        idx     = last_win;
        for (int k = NUM_FU; k >= 1; k--) begin
            idx = fu_idx_t'(last_win + k);
            if (fu_results[idx].valid) begin
                win     = idx;
                any_req = 1'b1;
            end
        end
    end

    always_comb begin
        fu_grant = '0;
        if (any_req) begin
            fu_grant[win] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_bus.valid <= 1'b0;
            last_win         <= fu_idx_t'(NUM_FU - 1);  // Unit 0 goes first.
        end else begin
            result_bus.valid <= any_req;
            if (any_req) begin
                result_bus.tag   <= fu_results[win].tag;
                result_bus.value <= fu_results[win].value;
                last_win         <= win;
            end
        end
    end

endmodule

`default_nettype wire

// ==== div_unit.sv ====
// Iterative unsigned divider.
// Radix-2 restoring divide, one quotient bit per cycle over XLEN cycles.

`timescale 1ns/1ns
`default_nettype none

module div_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  ooo_pkg::issue_t  issue,
    input  logic             grant,
    output logic             ready,
    output ooo_pkg::result_t result
);

    import isa_pkg::*;
    import ooo_pkg::*;

    localparam int STEP_W = $clog2(XLEN);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DONE
    } div_state_t;

    div_state_t        state;
    logic [STEP_W-1:0] step;
    xlen_t             quot;        // Dividend shifts out as quotient bits shift in.
    xlen_t             rem;
    xlen_t             divisor;
    rob_tag_t          tag;
    logic              want_rem;
    logic [XLEN+1:0]   trial;

    // Partial remainder with the next dividend bit, minus the divisor.
    // A zero divisor always succeeds, which yields all ones and the dividend.
    assign trial = {1'b0, rem, quot[XLEN-1]} - {2'b00, divisor};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            step  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_RUN;
                        step  <= '0;
                    end
                end
                S_RUN: begin
                    step <= step + 1'b1;
                    if (step == STEP_W'(XLEN - 1)) begin
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    if (grant) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && start) begin
            quot     <= issue.a;
            rem      <= '0;
            divisor  <= issue.b;
            tag      <= issue.dest;
            want_rem <= (issue.op == OP_REMU);
        end else if (state == S_RUN) begin
            if (trial[XLEN+1]) begin
                rem <= {rem[XLEN-2:0], quot[XLEN-1]};   // Restore.
            end else begin
                rem <= trial[XLEN-1:0];
            end
            quot <= {quot[XLEN-2:0], !trial[XLEN+1]};
        end
    end

    assign ready        = (state == S_IDLE);
    assign result.valid = (state == S_DONE);
    assign result.tag   = tag;
    assign result.value = want_rem ? rem : quot;

endmodule

`default_nettype wire

// ==== mul_unit.sv ====
// Pipelined unsigned multiplier.
// Product, tag and word select move down MUL_STAGES registers; the whole
// pipe stalls while the last stage waits for a grant.

`timescale 1ns/1ns
`default_nettype none

module mul_unit #(
    parameter int MUL_STAGES = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  ooo_pkg::issue_t  issue,
    input  logic             grant,
    output logic             ready,
    output ooo_pkg::result_t result
);

    import isa_pkg::*;
    import ooo_pkg::*;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        logic     hi;       // Return the upper product word.
        dxlen_t   prod;
    } mul_stage_t;

    mul_stage_t pipe [MUL_STAGES];
    logic       advance;

    assign advance = !pipe[MUL_STAGES-1].valid || grant;
    assign ready   = advance;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MUL_STAGES; i++) begin
                pipe[i].valid <= 1'b0;
            end
        end else if (advance) begin
            pipe[0].valid <= start;
            pipe[0].tag   <= issue.dest;
            pipe[0].hi    <= (issue.op == OP_MULH);
            pipe[0].prod  <= dxlen_t'(issue.a) * dxlen_t'(issue.b);
            for (int i = 1; i < MUL_STAGES; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign result.valid = pipe[MUL_STAGES-1].valid;
    assign result.tag   = pipe[MUL_STAGES-1].tag;
    assign result.value = pipe[MUL_STAGES-1].hi ? pipe[MUL_STAGES-1].prod[2*XLEN-1:XLEN]
                                                : pipe[MUL_STAGES-1].prod[XLEN-1:0];

endmodule

`default_nettype wire

// ==== alu_unit.sv ====
// Single-cycle integer ALU with shifts.
// Result is held in its output register until the arbiter grants it.

`timescale 1ns/1ns
`default_nettype none

module alu_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  ooo_pkg::issue_t  issue,
    input  logic             grant,
    output logic             ready,
    output ooo_pkg::result_t result
);

    import isa_pkg::*;

    xlen_t alu_out;

    always_comb begin
        case (issue.op)
            OP_ADD:  alu_out = issue.a + issue.b;
            OP_SUB:  alu_out = issue.a - issue.b;
            OP_AND:  alu_out = issue.a & issue.b;
            OP_OR:   alu_out = issue.a | issue.b;
            OP_XOR:  alu_out = issue.a ^ issue.b;
            OP_SLL:  alu_out = issue.a << issue.b[4:0];
            OP_SRL:  alu_out = issue.a >> issue.b[4:0];
            OP_SRA:  alu_out = xlen_t'($signed(issue.a) >>> issue.b[4:0]);
            default: alu_out = '0;
        endcase
    end

    // A granted result leaves this edge, so a new op may land on top of it.
    assign ready = !result.valid || grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else if (start) begin
            result.valid <= 1'b1;
            result.tag   <= issue.dest;
            result.value <= alu_out;
        end else if (grant) begin
            result.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== fu_scheduler.sv ====
// Functional-unit scheduler.
// Picks the lowest ready station entry that has a free unit of its class
// and sends it out with one-hot start and consume pulses.

`timescale 1ns/1ns
`default_nettype none

module fu_scheduler (
    input  ooo_pkg::rs_entry_t         rs_entries [ooo_pkg::NUM_RS],
    input  logic [ooo_pkg::NUM_FU-1:0] fu_ready,
    output ooo_pkg::issue_t            issue,
    output logic [ooo_pkg::NUM_FU-1:0] fu_start,
    output logic [ooo_pkg::NUM_RS-1:0] rs_consume
);

    import isa_pkg::*;
    import ooo_pkg::*;

    logic [NUM_FU-1:0] unit_sel [NUM_RS];   // Unit each entry would take, or none.

    // One-hot free unit that can run op, zero when its class is busy.
    function automatic logic [NUM_FU-1:0] free_unit(alu_op_t op, logic [NUM_FU-1:0] ready);
        logic [NUM_FU-1:0] sel;
        sel = '0;
        if (!op[3]) begin
            if (ready[FU_ALU0]) begin
                sel[FU_ALU0] = 1'b1;
            end else if (ready[FU_ALU1]) begin
                sel[FU_ALU1] = 1'b1;
            end
        end else if ((op == OP_MUL) || (op == OP_MULH)) begin
            sel[FU_MUL] = ready[FU_MUL];
        end else if ((op == OP_DIVU) || (op == OP_REMU)) begin
            sel[FU_DIV] = ready[FU_DIV];
        end
        return sel;
    endfunction

    always_comb begin
        for (int i = 0; i < NUM_RS; i++) begin
            unit_sel[i] = '0;
            if (rs_entries[i].valid && rs_entries[i].src1.ready
                    && rs_entries[i].src2.ready) begin
                unit_sel[i] = free_unit(rs_entries[i].op, fu_ready);
            end
        end
    end

    // ====================
    // Walk from the top so the lowest-numbered candidate wins.
    // A blocked entry leaves unit_sel clear and never shadows a later one.
    always_comb begin
        fu_start   = '0;
        rs_consume = '0;
        issue      = '0;
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            if (|unit_sel[i]) begin
                fu_start      = unit_sel[i];
                rs_consume    = '0;
                rs_consume[i] = 1'b1;
                issue.op      = rs_entries[i].op;
                issue.dest    = rs_entries[i].dest;
                issue.a       = rs_entries[i].src1.value;
                issue.b       = rs_entries[i].src2.value;
            end
        end
    end

endmodule

`default_nettype wire

// ==== reservation_station.sv ====
// Reservation station.
// Four entries that wait for operands, wake up from the result bus
// and free their slot when the scheduler issues them.

`timescale 1ns/1ns
`default_nettype none

module reservation_station (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       dispatch_valid,
    input  ooo_pkg::rs_entry_t         dispatch_entry,
    input  logic [ooo_pkg::NUM_RS-1:0] rs_consume,
    input  ooo_pkg::result_t           result_bus,
    output ooo_pkg::rs_entry_t         rs_entries [ooo_pkg::NUM_RS],
    output logic                       rs_full
);

    import ooo_pkg::*;

    logic [NUM_RS-1:0] slot_valid;
    logic [NUM_RS-1:0] alloc_sel;
    rs_entry_t         incoming;

    function automatic src_t wake(src_t src, result_t bus);
        src_t woke;
        woke = src;
        if (!src.ready && bus.valid && (bus.tag == src.tag)) begin
            woke.ready = 1'b1;
            woke.value = bus.value;
        end
        return woke;
    endfunction

    always_comb begin
        for (int i = 0; i < NUM_RS; i++) begin
            slot_valid[i] = rs_entries[i].valid;
        end
    end

    assign rs_full = &slot_valid;

    // Lowest clear bit of slot_valid, only on a dispatch strobe.
    assign alloc_sel = ~slot_valid & (slot_valid + 1'b1) & {NUM_RS{dispatch_valid}};

    always_comb begin
        incoming       = dispatch_entry;
        incoming.valid = 1'b1;
        incoming.src1  = wake(dispatch_entry.src1, result_bus);  // Same-cycle bypass.
        incoming.src2  = wake(dispatch_entry.src2, result_bus);
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_RS; i++) begin
            if (rst) begin
                rs_entries[i].valid <= 1'b0;
            end else if (alloc_sel[i]) begin
                rs_entries[i] <= incoming;
            end else if (rs_consume[i]) begin
                rs_entries[i].valid <= 1'b0;
            end else if (rs_entries[i].valid) begin
                rs_entries[i].src1 <= wake(rs_entries[i].src1, result_bus);
                rs_entries[i].src2 <= wake(rs_entries[i].src2, result_bus);
            end
        end
    end

endmodule

`default_nettype wire

// ==== ooo_pkg.sv ====
// Out-of-order core types.
// ROB tags, station entries, issue packets and result-bus beats.

`default_nettype none

package ooo_pkg;

    localparam int NUM_RS = 4;
    localparam int NUM_FU = 4;

    // Fixed unit slots on the start, ready and grant vectors.
    localparam int FU_ALU0 = 0;
    localparam int FU_ALU1 = 1;
    localparam int FU_MUL  = 2;
    localparam int FU_DIV  = 3;

    typedef logic [3:0]                rob_tag_t;
    typedef logic [$clog2(NUM_FU)-1:0] fu_idx_t;

    typedef struct packed {
        logic             ready;    // Value is present.
        rob_tag_t         tag;      // Producer to wait for otherwise.
        isa_pkg::xlen_t   value;
    } src_t;

    typedef struct packed {
        logic             valid;
        isa_pkg::alu_op_t op;
        rob_tag_t         dest;
        src_t             src1;
        src_t             src2;
    } rs_entry_t;

    typedef struct packed {
        isa_pkg::alu_op_t op;
        rob_tag_t         dest;
        isa_pkg::xlen_t   a;
        isa_pkg::xlen_t   b;
    } issue_t;

    typedef struct packed {
        logic             valid;
        rob_tag_t         tag;
        isa_pkg::xlen_t   value;
    } result_t;

endpackage

`default_nettype wire

// ==== isa_pkg.sv ====
// Integer ISA definitions.
// Data width and operation codes seen by the execute cluster.

`default_nettype none

package isa_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0]   xlen_t;     // One operand or result word.
    typedef logic [2*XLEN-1:0] dxlen_t;    // Full unsigned product.

    // ====================
    // Operation codes. Bit 3 set means the op does not run in an ALU.
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_SLL  = 4'h5,
        OP_SRL  = 4'h6,
        OP_SRA  = 4'h7,
        OP_MUL  = 4'h8,     // Low word of the product.
        OP_MULH = 4'h9,     // High word, unsigned by unsigned.
        OP_DIVU = 4'hA,
        OP_REMU = 4'hB
    } alu_op_t;

endpackage

`default_nettype wire
